// File: build.f
+incdir+.
isa_pkg.sv
pipe_pkg.sv
fetch.sv
decode.sv
hdu.sv
execute.sv
pipe_latch.sv
memory_wb.sv
proc.sv
tb_clock.sv
proc_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the processor testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
      -f build.f --top-module proc_tb -o proc_tb_sim; then
   echo "Verilator build failed"
   exit 1
fi

if ! ./obj_dir/proc_tb_sim > "$LOG" 2>&1; then
   cat "$LOG"
   echo "Simulation returned a failing status"
   exit 1
fi

cat "$LOG"
if grep -q "TESTBENCH PASSED" "$LOG"; then
   exit 0
fi
exit 1

// File: proc_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "proc_consts.svh"

module proc_tb;

   import isa_pkg::*;
   import pipe_pkg::*;

   localparam int IADDR_W      = $clog2(`PROC_IMEM_DEPTH);
   localparam int DADDR_W      = $clog2(`PROC_DMEM_DEPTH);
   localparam int HALT_TIMEOUT = 2000;
   localparam int QUIET_CYCLES = 20;
   localparam int MODEL_STEPS  = 200; // Guards the model against a runaway loop

   // One expected retire and the flags it should leave behind
   typedef struct packed {
      word_t      pc;
      logic       wr_en;
      logic [2:0] wr_reg;
      word_t      wr_data;
      logic       illegal;
      logic       halt;
   } expect_t;

   logic               clk;
   logic               rst;
   logic               imem_we;
   logic [IADDR_W-1:0] imem_addr;
   word_t              imem_data;
   retire_t            retire;
   logic               halted;
   logic               err;

   word_t   prog [`PROC_IMEM_DEPTH];
   int      prog_len;
   expect_t exp_q [$];
   integer  seed;
   int      cyc;       // Cycles since reset release
   logic    ill_seen;
   logic    halt_seen;
   int      wait_cnt;

   tb_clock #(.PERIOD_NS(4.0)) i_clock (.clk(clk));

   proc i_proc (
      .clk(clk), .rst(rst),
      .imem_we(imem_we), .imem_addr(imem_addr), .imem_data(imem_data),
      .retire(retire), .halted(halted), .err(err));

   task automatic abort_run();
      $display("TESTBENCH FAILED");
      $fatal(1);
   endtask

   task automatic report_error(input string what);
      $display("%s", what);
      abort_run();
   endtask

   task automatic value_error(input string name, input logic [31:0] exp_val,
                              input logic [31:0] act_val);
      $display("ERROR %s expected 0x%0h actual 0x%0h", name, exp_val, act_val);
      abort_run();
   endtask

   function automatic word_t rtype(input opcode_e op, input logic [2:0] rd,
                                   input logic [2:0] rs, input logic [2:0] rt);
      return {op, rd, rs, rt, 3'b000};
   endfunction

   function automatic word_t itype(input opcode_e op, input logic [2:0] rd,
                                   input logic [2:0] rs, input logic [5:0] imm);
      return {op, rd, rs, imm};
   endfunction

   function automatic word_t btype(input opcode_e op, input logic [2:0] rd,
                                   input logic [8:0] imm);
      return {op, rd, imm};
   endfunction

   task automatic put_word(input word_t w);
      prog[prog_len] = w;
      prog_len++;
   endtask

   task automatic build_program();
      opcode_e     alu_ops [4] = '{OP_ADD, OP_SUB, OP_AND, OP_XOR};
      int unsigned sel;
      logic [2:0]  rd;
      logic [2:0]  rs;
      logic [2:0]  rt;
      // Unused words hold LBI r1 with their own address
      for (int a = 0; a < `PROC_IMEM_DEPTH; a++) begin
         prog[a] = btype(OP_LBI, 3'd1, 9'(a));
      end
      prog_len = 0;
      put_word(btype(OP_LBI, 3'd1, 9'($random(seed))));
      put_word(btype(OP_LBI, 3'd2, 9'($random(seed))));
      put_word(btype(OP_LBI, 3'd3, 9'($random(seed))));
      // Random ALU block
      for (int n = 0; n < 8; n++) begin
         sel = n % 5;
         rd  = 3'($random(seed));
         rs  = 3'($random(seed));
         rt  = 3'($random(seed));
         if (sel == 4) begin
            put_word(itype(OP_ADDI, rd, rs, 6'($random(seed))));
         end else begin
            put_word(rtype(alu_ops[sel], rd, rs, rt));
         end
      end
      // Each one reads the previous result
      put_word(itype(OP_ADDI, 3'd3, 3'd3, 6'h05));
      put_word(rtype(OP_ADD, 3'd3, 3'd3, 3'd1));
      put_word(rtype(OP_SUB, 3'd4, 3'd3, 3'd2));
      put_word(rtype(OP_XOR, 3'd5, 3'd4, 3'd3));
      put_word(btype(OP_LBI, 3'd5, 9'd0));
      put_word(btype(OP_BEQZ, 3'd5, 9'd2));    // Taken
      put_word(btype(OP_LBI, 3'd6, 9'h011));   // Skipped
      put_word(btype(OP_LBI, 3'd7, 9'h022));   // Skipped
      put_word(btype(OP_LBI, 3'd6, 9'h033));   // Branch target
      put_word(btype(OP_LBI, 3'd5, 9'h1fe));
      put_word(btype(OP_BEQZ, 3'd5, 9'd1));    // Not taken
      put_word(btype(OP_LBI, 3'd7, 9'h044));
      // Store then load back through two address forms
      put_word(btype(OP_LBI, 3'd1, 9'd20));
      put_word(btype(OP_LBI, 3'd2, 9'($random(seed))));
      put_word(itype(OP_ST, 3'd2, 3'd1, 6'd3));
      put_word(itype(OP_LD, 3'd4, 3'd1, 6'd3));
      put_word(itype(OP_ADDI, 3'd3, 3'd1, 6'd5));
      put_word(itype(OP_LD, 3'd5, 3'd3, 6'h3e));
      put_word({4'hc, 12'h2d1});               // Illegal opcode
      put_word(rtype(OP_ADD, 3'd6, 3'd4, 3'd5));
      put_word(btype(OP_HALT, 3'd0, 9'd0));
   endtask

   // In-order interpreter of the ISA giving one expected record per instruction
   task automatic run_model();
      word_t   regs [`PROC_REG_CNT];
      word_t   dmem [`PROC_DMEM_DEPTH];
      word_t   pc;
      word_t   next_pc;
      word_t   w;
      word_t   addr;
      expect_t e;
      logic    done;
      int      steps;
      for (int i = 0; i < `PROC_REG_CNT; i++) begin
         regs[i] = '0;
      end
      for (int i = 0; i < `PROC_DMEM_DEPTH; i++) begin
         dmem[i] = '0;
      end
      pc    = '0;
      done  = 1'b0;
      steps = 0;
      while (!done && steps < MODEL_STEPS) begin
         w         = prog[pc[IADDR_W-1:0]];
         e         = '0;
         e.pc      = pc;
         e.wr_reg  = w[11:9];
         next_pc   = pc + 16'd1;
         addr      = regs[w[8:6]] + word_t'($signed(w[5:0]));
         case (w[15:12])
            OP_ADD: begin
               e.wr_en   = 1'b1;
               e.wr_data = regs[w[8:6]] + regs[w[5:3]];
            end
            OP_SUB: begin
               e.wr_en   = 1'b1;
               e.wr_data = regs[w[8:6]] - regs[w[5:3]];
            end
            OP_AND: begin
               e.wr_en   = 1'b1;
               e.wr_data = regs[w[8:6]] & regs[w[5:3]];
            end
            OP_XOR: begin
               e.wr_en   = 1'b1;
               e.wr_data = regs[w[8:6]] ^ regs[w[5:3]];
            end
            OP_ADDI: begin
               e.wr_en   = 1'b1;
               e.wr_data = addr;
            end
            OP_LBI: begin
               e.wr_en   = 1'b1;
               e.wr_data = word_t'($signed(w[8:0]));
            end
            OP_LD: begin
               e.wr_en   = 1'b1;
               e.wr_data = dmem[addr[DADDR_W-1:0]];
            end
            OP_ST:   dmem[addr[DADDR_W-1:0]] = regs[w[11:9]];
            OP_BEQZ: begin
               if (regs[w[11:9]] == '0) begin
                  next_pc = pc + 16'd1 + word_t'($signed(w[8:0]));
               end
            end
            OP_HALT: begin
               e.halt = 1'b1;
               done   = 1'b1;
            end
            default: e.illegal = 1'b1;
         endcase
         if (e.wr_en) begin
            regs[e.wr_reg] = e.wr_data;
         end
         exp_q.push_back(e);
         pc = next_pc;
         steps++;
      end
   endtask

   task automatic check_retire();
      expect_t e;
      if (exp_q.size() == 0) begin
         report_error("A retire arrived after the expected stream had ended");
      end else begin
         e = exp_q.pop_front();
         assert (retire.pc == e.pc)
            else value_error("retire.pc", 32'(e.pc), 32'(retire.pc));
         assert (retire.wr_en == e.wr_en)
            else value_error("retire.wr_en", 32'(e.wr_en), 32'(retire.wr_en));
         if (e.wr_en) begin
            assert (retire.wr_reg == e.wr_reg)
               else value_error("retire.wr_reg", 32'(e.wr_reg), 32'(retire.wr_reg));
            assert (retire.wr_data == e.wr_data)
               else value_error("retire.wr_data", 32'(e.wr_data), 32'(retire.wr_data));
         end
         ill_seen  = ill_seen | e.illegal;
         halt_seen = halt_seen | e.halt;
         assert (err == ill_seen) else value_error("err", 32'(ill_seen), 32'(err));
         assert (halted == halt_seen) else value_error("halted", 32'(halt_seen), 32'(halted));
      end
   endtask

   // Outputs sampled mid-cycle away from the driving edge
   always @(negedge clk) begin
      if (rst) begin
         cyc = 0;
         assert (!retire.valid && !halted && !err)
            else report_error("retire, halted or err was active during reset");
      end else begin
         assert (cyc >= 4 || !retire.valid)
            else report_error("A retire appeared before the pipeline could fill");
         if (retire.valid) begin
            check_retire();
         end else begin
            assert (halted == halt_seen) else value_error("halted", 32'(halt_seen), 32'(halted));
            assert (err == ill_seen) else value_error("err", 32'(ill_seen), 32'(err));
         end
         cyc++;
      end
   end

   halted_sticky: assert property (@(posedge clk) disable iff (rst) $past(halted) |-> halted)
      else report_error("halted fell after it had risen");

   err_sticky: assert property (@(posedge clk) disable iff (rst) $past(err) |-> err)
      else report_error("err fell after it had risen");

   initial begin
      seed      = 32'hce65_8e51;
      rst       = 1'b1;
      imem_we   = 1'b0;
      imem_addr = '0;
      imem_data = '0;
      cyc       = 0;
      ill_seen  = 1'b0;
      halt_seen = 1'b0;
      build_program();
      run_model();
      // Whole instruction memory written while the core sits in reset
      for (int a = 0; a < `PROC_IMEM_DEPTH; a++) begin
         @(posedge clk);
         imem_we   <= 1'b1;
         imem_addr <= IADDR_W'(a);
         imem_data <= prog[a];
      end
      @(posedge clk);
      imem_we <= 1'b0;
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      wait_cnt = 0;
      while (!halted && wait_cnt < HALT_TIMEOUT) begin
         @(negedge clk);
         wait_cnt++;
      end
      if (!halted) begin
         report_error("The processor never halted within 2000 cycles");
      end else begin
         // Quiet period after the halt
         for (int n = 0; n < QUIET_CYCLES; n++) begin
            @(negedge clk);
         end
         @(posedge clk);
         if (exp_q.size() != 0) begin
            $display("%0d expected retires never arrived", exp_q.size());
            abort_run();
         end else begin
            $display("TESTBENCH PASSED");
            $finish;
         end
      end
   end

endmodule

`default_nettype wire

// File: tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
   parameter real PERIOD_NS = 4.0
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2.0) clk = ~clk;
   end

endmodule

`default_nettype wire

// File: proc.sv
`timescale 1ns/100ps
`default_nettype none
`include "proc_consts.svh"

module proc (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                imem_we,
   input  logic [$clog2(`PROC_IMEM_DEPTH)-1:0] imem_addr,
   input  logic [`PROC_WORD_W-1:0]             imem_data,
   output pipe_pkg::retire_t                   retire,
   output logic                                halted,
   output logic                                err
);

   import pipe_pkg::*;

   fd_t fd;
   fd_t fd_q;
   de_t de;
   de_t de_q;
   em_t em;
   em_t em_q;
   mw_t mw;
   mw_t mw_q;

   logic                    wb_en;
   logic [2:0]              wb_reg;
   logic [`PROC_WORD_W-1:0] wb_data;
   logic [2:0]              rd_rs;
   logic [2:0]              rd_rt;
   logic                    uses_rs;
   logic                    uses_rt;
   logic                    stall;
   logic                    flush;
   logic                    branch_taken;
   logic [`PROC_WORD_W-1:0] branch_pc;

   fetch i_fetch (
      .clk(clk), .rst(rst),
      .imem_we(imem_we), .imem_addr(imem_addr), .imem_data(imem_data),
      .hold(stall), .redirect(flush), .redirect_pc(branch_pc),
      .halted(halted), .fd(fd));

   // Stall holds the front, flush kills both younger slots
   pipe_latch #(.payload_t(fd_t)) i_fd_latch (
      .clk(clk), .rst(rst), .hold(stall), .bubble(flush), .d(fd), .q(fd_q));

   decode i_decode (
      .clk(clk), .rst(rst), .fd(fd_q),
      .wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data),
      .de(de), .rd_rs(rd_rs), .rd_rt(rd_rt), .uses_rs(uses_rs), .uses_rt(uses_rt));

   hdu i_hdu (
      .rd_rs(rd_rs), .rd_rt(rd_rt), .uses_rs(uses_rs), .uses_rt(uses_rt),
      .de_q(de_q), .em_q(em_q), .mw_q(mw_q),
      .branch_taken(branch_taken), .stall(stall), .flush(flush));

   pipe_latch #(.payload_t(de_t)) i_de_latch (
      .clk(clk), .rst(rst), .hold(1'b0), .bubble(stall | flush), .d(de), .q(de_q));

   execute i_execute (
      .de_q(de_q), .em(em), .branch_taken(branch_taken), .branch_pc(branch_pc));

   pipe_latch #(.payload_t(em_t)) i_em_latch (
      .clk(clk), .rst(rst), .hold(1'b0), .bubble(1'b0), .d(em), .q(em_q));

   pipe_latch #(.payload_t(mw_t)) i_mw_latch (
      .clk(clk), .rst(rst), .hold(1'b0), .bubble(1'b0), .d(mw), .q(mw_q));

   memory_wb i_memory_wb (
      .clk(clk), .rst(rst), .em_q(em_q), .mw_q(mw_q), .mw(mw),
      .wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data),
      .retire(retire), .halted(halted), .err(err));

endmodule

`default_nettype wire

// File: memory_wb.sv
`timescale 1ns/100ps
`default_nettype none
`include "proc_consts.svh"

module memory_wb (
   input  logic                    clk,
   input  logic                    rst,
   input  pipe_pkg::em_t           em_q,
   input  pipe_pkg::mw_t           mw_q,
   output pipe_pkg::mw_t           mw,
   output logic                    wb_en,
   output logic [2:0]              wb_reg,
   output logic [`PROC_WORD_W-1:0] wb_data,
   output pipe_pkg::retire_t       retire,
   output logic                    halted,
   output logic                    err
);

   localparam int DADDR_W = $clog2(`PROC_DMEM_DEPTH);

   logic [`PROC_WORD_W-1:0] dmem [`PROC_DMEM_DEPTH];
   logic [`PROC_WORD_W-1:0] ld_data;
   logic [DADDR_W-1:0]      daddr;
   logic                    retiring;
   logic                    halted_q;
   logic                    err_q;

   assign daddr = em_q.alu_res[DADDR_W-1:0];

   // Nothing younger than a retiring HALT may store
   always_ff @(posedge clk) begin
      if (em_q.valid && em_q.ctrl.mem_write && !halted) begin
         dmem[daddr] <= em_q.st_data;
      end
      if (em_q.valid && em_q.ctrl.mem_read) begin
         ld_data <= dmem[daddr]; // Travels alongside the mw latch
      end
   end

   assign mw = '{valid:  em_q.valid,
                 pc:     em_q.pc,
                 result: em_q.alu_res,
                 load:   em_q.ctrl.mem_read,
                 ctrl:   em_q.ctrl,
                 wr_reg: em_q.wr_reg};

   assign retiring = mw_q.valid && !halted_q;
   assign wb_en    = retiring && mw_q.ctrl.reg_write;
   assign wb_reg   = mw_q.wr_reg;
   assign wb_data  = mw_q.load ? ld_data : mw_q.result;

   assign retire = '{valid:   retiring,
                     pc:      mw_q.pc,
                     wr_en:   wb_en,
                     wr_reg:  wb_reg,
                     wr_data: wb_data};

   // Both flags rise with the retiring instruction itself
   assign halted = halted_q || (retiring && mw_q.ctrl.halt);
   assign err    = err_q || (retiring && mw_q.ctrl.illegal);

   always_ff @(posedge clk) begin
      if (rst) begin
         halted_q <= 1'b0;
         err_q    <= 1'b0;
      end else begin
         halted_q <= halted;
         err_q    <= err;
      end
   end

endmodule

`default_nettype wire

// File: pipe_latch.sv
`timescale 1ns/100ps
`default_nettype none

module pipe_latch #(
   parameter type payload_t = logic [1:0]
) (
   input  logic     clk,
   input  logic     rst,
   input  logic     hold,
   input  logic     bubble,
   input  payload_t d,
   output payload_t q
);

   localparam int PAYLOAD_W = $bits(payload_t);

   always_ff @(posedge clk) begin
      if (rst) begin
         q <= '0;
      end else if (!hold) begin
         if (bubble) begin
            q <= payload_t'({1'b0, d[PAYLOAD_W-2:0]}); // Valid is the top bit
         end else begin
            q <= d;
         end
      end
   end

endmodule

`default_nettype wire

// File: execute.sv
`timescale 1ns/100ps
`default_nettype none
`include "proc_consts.svh"

module execute (
   input  pipe_pkg::de_t           de_q,
   output pipe_pkg::em_t           em,
   output logic                    branch_taken,
   output logic [`PROC_WORD_W-1:0] branch_pc
);

   import isa_pkg::*;

   logic [`PROC_WORD_W-1:0] opnd_b;
   logic [`PROC_WORD_W-1:0] alu_res;
   logic [`PROC_WORD_W-1:0] br_off;

   assign opnd_b = de_q.use_imm ? de_q.imm : de_q.op_b;

   always_comb begin
      case (de_q.alu_op)
         ALU_ADD: alu_res = de_q.op_a + opnd_b;
         ALU_SUB: alu_res = de_q.op_a - opnd_b;
         ALU_AND: alu_res = de_q.op_a & opnd_b;
         default: alu_res = de_q.op_a ^ opnd_b; // ALU_XOR
      endcase
   end

   // BEQZ tests rd, carried in st_data
   assign br_off       = {{(`PROC_WORD_W-9){de_q.imm9[8]}}, de_q.imm9};
   assign branch_taken = de_q.valid && de_q.ctrl.branch && (de_q.st_data == '0);
   assign branch_pc    = de_q.pc + `PROC_WORD_W'(1) + br_off;

   assign em = '{valid:   de_q.valid,
                 pc:      de_q.pc,
                 alu_res: alu_res,
                 st_data: de_q.st_data,
                 ctrl:    de_q.ctrl,
                 wr_reg:  de_q.wr_reg};

endmodule

`default_nettype wire

// File: hdu.sv
`timescale 1ns/100ps
`default_nettype none

module hdu (
   input  logic          [2:0] rd_rs,
   input  logic          [2:0] rd_rt,
   input  logic                uses_rs,
   input  logic                uses_rt,
   input  pipe_pkg::de_t       de_q,
   input  pipe_pkg::em_t       em_q,
   input  pipe_pkg::mw_t       mw_q,
   input  logic                branch_taken,
   output logic                stall,
   output logic                flush
);

   logic rs_hit;
   logic rt_hit;

   function automatic logic pending(input logic vld, input logic we,
                                    input logic [2:0] dst, input logic [2:0] src);
      return vld && we && (dst == src);
   endfunction

   // Writeback counts too, its write lands after the decode read
   assign rs_hit = uses_rs &&
                   (pending(de_q.valid, de_q.ctrl.reg_write, de_q.wr_reg, rd_rs) ||
                    pending(em_q.valid, em_q.ctrl.reg_write, em_q.wr_reg, rd_rs) ||
                    pending(mw_q.valid, mw_q.ctrl.reg_write, mw_q.wr_reg, rd_rs));

   assign rt_hit = uses_rt &&
                   (pending(de_q.valid, de_q.ctrl.reg_write, de_q.wr_reg, rd_rt) ||
                    pending(em_q.valid, em_q.ctrl.reg_write, em_q.wr_reg, rd_rt) ||
                    pending(mw_q.valid, mw_q.ctrl.reg_write, mw_q.wr_reg, rd_rt));

   assign flush = branch_taken;
   assign stall = (rs_hit || rt_hit) && !branch_taken; // Flush wins

endmodule

`default_nettype wire

// File: decode.sv
`timescale 1ns/100ps
`default_nettype none
`include "proc_consts.svh"

module decode (
   input  logic                    clk,
   input  logic                    rst,
   input  pipe_pkg::fd_t           fd,
   input  logic                    wb_en,
   input  logic [2:0]              wb_reg,
   input  logic [`PROC_WORD_W-1:0] wb_data,
   output pipe_pkg::de_t           de,
   output logic [2:0]              rd_rs,
   output logic [2:0]              rd_rt,
   output logic                    uses_rs,
   output logic                    uses_rt
);

   import isa_pkg::*;
   import pipe_pkg::*;

   logic [`PROC_WORD_W-1:0] rf [`PROC_REG_CNT];
   instr_t                  ins;
   ctrl_t                   ctrl;
   alu_op_e                 alu_op;
   logic                    use_imm;
   logic                    rs_used;
   logic                    rt_used;
   logic                    rd_src;  // rd is read on the second port
   logic                    is_lbi;
   logic [`PROC_WORD_W-1:0] imm6_x;
   logic [`PROC_WORD_W-1:0] imm9_x;

   assign ins    = fd.instr;
   assign imm6_x = {{(`PROC_WORD_W-6){ins.i.imm6[5]}}, ins.i.imm6};
   assign imm9_x = {{(`PROC_WORD_W-9){ins.b.imm9[8]}}, ins.b.imm9};

   // Same-cycle writes are not seen by the read side
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < `PROC_REG_CNT; i++) begin
            rf[i] <= '0;
         end
      end else if (wb_en) begin
         rf[wb_reg] <= wb_data;
      end
   end

   always_comb begin
      ctrl    = '0;
      alu_op  = ALU_ADD;
      use_imm = 1'b0;
      rs_used = 1'b0;
      rt_used = 1'b0;
      rd_src  = 1'b0;
      is_lbi  = 1'b0;
      case (ins.r.opcode)
         OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
            ctrl.reg_write = 1'b1;
            alu_op         = alu_op_e'(ins.r.opcode[1:0]);
            rs_used        = 1'b1;
            rt_used        = 1'b1;
         end
         OP_ADDI: begin
            ctrl.reg_write = 1'b1;
            use_imm        = 1'b1;
            rs_used        = 1'b1;
         end
         OP_LBI: begin
            ctrl.reg_write = 1'b1;
            use_imm        = 1'b1;
            is_lbi         = 1'b1; // 0 + imm9
         end
         OP_LD: begin
            ctrl.reg_write = 1'b1;
            ctrl.mem_read  = 1'b1;
            use_imm        = 1'b1;
            rs_used        = 1'b1;
         end
         OP_ST: begin
            ctrl.mem_write = 1'b1;
            use_imm        = 1'b1;
            rs_used        = 1'b1;
            rt_used        = 1'b1;
            rd_src         = 1'b1;
         end
         OP_BEQZ: begin
            ctrl.branch = 1'b1;
            rt_used     = 1'b1;
            rd_src      = 1'b1;
         end
         OP_HALT: ctrl.halt = 1'b1;
         default: ctrl.illegal = 1'b1; // No write, no memory access
      endcase
   end

   assign rd_rs   = ins.r.rs;
   assign rd_rt   = rd_src ? ins.r.rd : ins.r.rt;
   assign uses_rs = fd.valid && rs_used;
   assign uses_rt = fd.valid && rt_used;

   assign de = '{valid:   fd.valid,
                 pc:      fd.pc,
                 alu_op:  alu_op,
                 use_imm: use_imm,
                 op_a:    is_lbi ? '0 : rf[rd_rs],
                 op_b:    rf[rd_rt],
                 imm:     is_lbi ? imm9_x : imm6_x,
                 st_data: rf[rd_rt],
                 ctrl:    ctrl,
                 wr_reg:  ins.r.rd,
                 imm9:    ins.b.imm9};

endmodule

`default_nettype wire

// File: fetch.sv
`timescale 1ns/100ps
`default_nettype none
`include "proc_consts.svh"

module fetch (
   input  logic                                  clk,
   input  logic                                  rst,
   input  logic                                  imem_we,
   input  logic [$clog2(`PROC_IMEM_DEPTH)-1:0]   imem_addr,
   input  logic [`PROC_WORD_W-1:0]               imem_data,
   input  logic                                  hold,
   input  logic                                  redirect,
   input  logic [`PROC_WORD_W-1:0]               redirect_pc,
   input  logic                                  halted,
   output pipe_pkg::fd_t                         fd
);

   import isa_pkg::*;

   localparam int IADDR_W = $clog2(`PROC_IMEM_DEPTH);

   logic [`PROC_WORD_W-1:0] imem [`PROC_IMEM_DEPTH];
   logic [`PROC_WORD_W-1:0] pc;

   // Loader port, used while the core sits in reset
   always_ff @(posedge clk) begin
      if (imem_we) begin
         imem[imem_addr] <= imem_data;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         pc <= '0;
      end else if (!halted) begin
         if (redirect) begin
            pc <= redirect_pc; // Taken branch from execute
         end else if (!hold) begin
            pc <= pc + 1'b1;
         end
      end
   end

   // PC counts words, upper bits ignored for the lookup
   assign fd = '{valid: !halted,
                 pc:    pc,
                 instr: instr_t'(imem[pc[IADDR_W-1:0]])};

endmodule

`default_nettype wire

// File: pipe_pkg.sv
`default_nettype none
`include "proc_consts.svh"

package pipe_pkg;

   typedef logic [`PROC_WORD_W-1:0] word_t;

   typedef struct packed {
      logic reg_write;
      logic mem_read;
      logic mem_write;
      logic branch;
      logic halt;
      logic illegal;
   } ctrl_t;

   // Valid stays the top field of every stage payload
   typedef struct packed {
      logic            valid;
      word_t           pc;
      isa_pkg::instr_t instr;
   } fd_t;

   typedef struct packed {
      logic             valid;
      word_t            pc;
      isa_pkg::alu_op_e alu_op;
      logic             use_imm;
      word_t            op_a;
      word_t            op_b;
      word_t            imm;
      word_t            st_data;  // Also the BEQZ test value
      ctrl_t            ctrl;
      logic [2:0]       wr_reg;
      logic [8:0]       imm9;
   } de_t;

   typedef struct packed {
      logic       valid;
      word_t      pc;
      word_t      alu_res;
      word_t      st_data;
      ctrl_t      ctrl;
      logic [2:0] wr_reg;
   } em_t;

   typedef struct packed {
      logic       valid;
      word_t      pc;
      word_t      result;
      logic       load;
      ctrl_t      ctrl;
      logic [2:0] wr_reg;
   } mw_t;

   typedef struct packed {
      logic       valid;
      word_t      pc;
      logic       wr_en;
      logic [2:0] wr_reg;
      word_t      wr_data;
   } retire_t;

endpackage

`default_nettype wire

// File: isa_pkg.sv
`default_nettype none

package isa_pkg;

   // R-type opcodes share their low two bits with alu_op_e
   typedef enum logic [3:0] {
      OP_ADD  = 4'h0,
      OP_SUB  = 4'h1,
      OP_AND  = 4'h2,
      OP_XOR  = 4'h3,
      OP_ADDI = 4'h4,
      OP_LBI  = 4'h5,
      OP_LD   = 4'h6,
      OP_ST   = 4'h7,
      OP_BEQZ = 4'h8,
      OP_HALT = 4'h9
   } opcode_e;

   typedef enum logic [1:0] {
      ALU_ADD = 2'd0,
      ALU_SUB = 2'd1,
      ALU_AND = 2'd2,
      ALU_XOR = 2'd3
   } alu_op_e;

   typedef struct packed {
      opcode_e    opcode;
      logic [2:0] rd;
      logic [2:0] rs;
      logic [2:0] rt;
      logic [2:0] spare;
   } r_fmt_t;

   typedef struct packed {
      opcode_e           opcode;
      logic [2:0]        rd;
      logic [2:0]        rs;
      logic signed [5:0] imm6; // ADDI, LD, ST offset
   } i_fmt_t;

   typedef struct packed {
      opcode_e           opcode;
      logic [2:0]        rd;
      logic signed [8:0] imm9; // LBI value, BEQZ offset
   } b_fmt_t;

   // Three views of the same 16-bit word
   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
      b_fmt_t b;
   } instr_t;

endpackage

`default_nettype wire

// File: proc_consts.svh
`ifndef PROC_CONSTS_SVH
`define PROC_CONSTS_SVH

// Data and instruction width
`define PROC_WORD_W 16

// Architectural registers
`define PROC_REG_CNT 8

`define PROC_IMEM_DEPTH 64 // Words
`define PROC_DMEM_DEPTH 64 // Words

`endif
